// ==== src/wb_pkg.sv ====
package wb_pkg;

	// Port counts
	localparam int NUM_CTRL = 3;
	localparam int NUM_DEV  = 6;

	// Bus widths
	localparam int ADR_W     = 28;
	localparam int DEV_ADR_W = 24;
	localparam int DATA_W    = 32;
	localparam int SEL_W     = 4;

	// Device field sits in the top bits of the controller address
	localparam int DEV_IDX_W = ADR_W - DEV_ADR_W;

	// Wide enough to name any controller
	localparam int CTRL_IDX_W = 2;

	// Read data returned for an unmapped device field
	localparam logic [DATA_W-1:0] UNMAPPED_DATA = '1;

	typedef logic [DEV_IDX_W-1:0]  dev_idx_t;
	typedef logic [CTRL_IDX_W-1:0] ctrl_idx_t;

	// Controller side request
	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [SEL_W-1:0]  sel;
		logic [DATA_W-1:0] data;
		logic [ADR_W-1:0]  adr;
	} wb_req_t;

	// Device side request, device field stripped
	typedef struct packed {
		logic                 cyc;
		logic                 stb;
		logic                 we;
		logic [SEL_W-1:0]     sel;
		logic [DATA_W-1:0]    data;
		logic [DEV_ADR_W-1:0] adr;
	} wb_dev_req_t;

	// Response, same shape in both directions
	typedef struct packed {
		logic              ack;
		logic              stall;
		logic              error;
		logic [DATA_W-1:0] data;
	} wb_rsp_t;

	// Per-device arbiter state
	typedef enum logic {
		ARB_IDLE = 1'b0,
		ARB_BUSY = 1'b1
	} arb_state_t;

endpackage

// ==== src/wb_addr_decode.sv ====
`timescale 1ns/1ps

module wb_addr_decode import wb_pkg::*; (
	input  wb_req_t             ctrl_req_i [NUM_CTRL],
	output dev_idx_t            dev_idx_o  [NUM_CTRL],
	output logic [NUM_CTRL-1:0] mapped_o,
	output logic [NUM_CTRL-1:0] dev_sel_o  [NUM_DEV]
);

	dev_idx_t dev_idx [NUM_CTRL];

	// Device field of every controller address
	always_comb begin
		for (int c = 0; c < NUM_CTRL; c++) begin
			dev_idx[c] = ctrl_req_i[c].adr[ADR_W-1 -: DEV_IDX_W];
		end
	end

	// Indices at or above NUM_DEV have no device behind them
	always_comb begin
		for (int c = 0; c < NUM_CTRL; c++) begin
			mapped_o[c] = dev_idx[c] < dev_idx_t'(NUM_DEV);
		end
	end

	// One request line per controller into each device arbiter
	always_comb begin
		for (int d = 0; d < NUM_DEV; d++) begin
			for (int c = 0; c < NUM_CTRL; c++) begin
				dev_sel_o[d][c] = ctrl_req_i[c].cyc && (dev_idx[c] == dev_idx_t'(d));
			end
		end
	end

	assign dev_idx_o = dev_idx;

endmodule

// ==== src/wb_device_arbiter.sv ====
`timescale 1ns/1ps

module wb_device_arbiter import wb_pkg::*; (
	input  logic                wb_clk_i,
	input  logic                rst_n_i,

	// Controller side
	input  logic [NUM_CTRL-1:0] req_sel_i,
	input  wb_req_t             ctrl_req_i [NUM_CTRL],
	output wb_rsp_t             ctrl_rsp_o [NUM_CTRL],

	// Device side
	output wb_dev_req_t         dev_req_o,
	input  wb_rsp_t             dev_rsp_i
);

	arb_state_t state_q;
	arb_state_t state_d;
	ctrl_idx_t  grant_q;
	ctrl_idx_t  grant_d;
	ctrl_idx_t  lowest_req;
	wb_req_t    granted_req;
	logic       granted_cyc;
	logic       busy;

	// Lowest-numbered requester wins, so scan downwards
	always_comb begin
		lowest_req = '0;
		for (int c = NUM_CTRL - 1; c >= 0; c--) begin
			if (req_sel_i[c]) begin
				lowest_req = ctrl_idx_t'(c);
			end
		end
	end

	assign granted_req = ctrl_req_i[grant_q];
	assign granted_cyc = req_sel_i[grant_q];
	assign busy        = (state_q == ARB_BUSY);

	// Grant FSM
	always_comb begin
		state_d = state_q;
		grant_d = grant_q;
		case (state_q)
			ARB_IDLE: begin
				if (|req_sel_i) begin
					state_d = ARB_BUSY;
					grant_d = lowest_req;
				end
			end
			ARB_BUSY: begin
				// Owner keeps the device until its cyc drops
				if (!granted_cyc) begin
					state_d = ARB_IDLE;
				end
			end
			default: begin
				state_d = ARB_IDLE;
			end
		endcase
	end

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			state_q <= ARB_IDLE;
			grant_q <= '0;
		end else begin
			state_q <= state_d;
			grant_q <= grant_d;
		end
	end

	// Request path to the device
	always_comb begin
		dev_req_o.cyc  = 1'b0;
		dev_req_o.stb  = 1'b0;
		dev_req_o.we   = granted_req.we;
		dev_req_o.sel  = granted_req.sel;
		dev_req_o.data = granted_req.data;
		dev_req_o.adr  = granted_req.adr[DEV_ADR_W-1:0];
		if (busy) begin
			dev_req_o.cyc = granted_cyc;
			dev_req_o.stb = granted_cyc && granted_req.stb;
		end
	end

	// Owner sees the device, everyone else waiting is stalled
	always_comb begin
		for (int c = 0; c < NUM_CTRL; c++) begin
			ctrl_rsp_o[c].ack   = 1'b0;
			ctrl_rsp_o[c].stall = req_sel_i[c];
			ctrl_rsp_o[c].error = 1'b0;
			ctrl_rsp_o[c].data  = dev_rsp_i.data;
			if (busy && (grant_q == ctrl_idx_t'(c))) begin
				ctrl_rsp_o[c] = dev_rsp_i;
			end
		end
	end

endmodule

// ==== src/wb_response_mux.sv ====
`timescale 1ns/1ps

module wb_response_mux import wb_pkg::*; (
	input  dev_idx_t            dev_idx_i  [NUM_CTRL],
	input  logic [NUM_CTRL-1:0] mapped_i,
	input  wb_req_t             ctrl_req_i [NUM_CTRL],

	// Every arbiter answers every controller
	input  wb_rsp_t             arb_rsp_i  [NUM_DEV][NUM_CTRL],

	output wb_rsp_t             ctrl_rsp_o [NUM_CTRL]
);

	wb_rsp_t mapped_rsp   [NUM_CTRL];
	wb_rsp_t unmapped_rsp [NUM_CTRL];

	// Pick the arbiter this controller is addressing
	always_comb begin
		for (int c = 0; c < NUM_CTRL; c++) begin
			mapped_rsp[c] = '0;
			for (int d = 0; d < NUM_DEV; d++) begin
				if (dev_idx_i[c] == dev_idx_t'(d)) begin
					mapped_rsp[c] = arb_rsp_i[d][c];
				end
			end
		end
	end

	// Nothing there, acknowledge right away with all ones
	always_comb begin
		for (int c = 0; c < NUM_CTRL; c++) begin
			unmapped_rsp[c].ack   = ctrl_req_i[c].cyc;
			unmapped_rsp[c].stall = 1'b0;
			unmapped_rsp[c].error = 1'b0;
			unmapped_rsp[c].data  = UNMAPPED_DATA;
		end
	end

	always_comb begin
		for (int c = 0; c < NUM_CTRL; c++) begin
			if (mapped_i[c]) begin
				ctrl_rsp_o[c] = mapped_rsp[c];
			end else begin
				ctrl_rsp_o[c] = unmapped_rsp[c];
			end
		end
	end

endmodule

// ==== src/wb_interconnect.sv ====
`timescale 1ns/1ps

module wb_interconnect import wb_pkg::*; (
	input  logic        wb_clk_i,
	input  logic        rst_n_i,

	// Controller ports
	input  wb_req_t     ctrl_req_i [NUM_CTRL],
	output wb_rsp_t     ctrl_rsp_o [NUM_CTRL],

	// Device ports
	output wb_dev_req_t dev_req_o  [NUM_DEV],
	input  wb_rsp_t     dev_rsp_i  [NUM_DEV]
);

	dev_idx_t            dev_idx [NUM_CTRL];
	logic [NUM_CTRL-1:0] mapped;
	logic [NUM_CTRL-1:0] dev_sel [NUM_DEV];
	wb_rsp_t             arb_rsp [NUM_DEV][NUM_CTRL];

	// Address decode
	wb_addr_decode u_addr_decode (
		.ctrl_req_i (ctrl_req_i),
		.dev_idx_o  (dev_idx),
		.mapped_o   (mapped),
		.dev_sel_o  (dev_sel)
	);

	// One arbiter in front of each device
	genvar d;
	generate
		for (d = 0; d < NUM_DEV; d++) begin : g_dev
			wb_device_arbiter u_arbiter (
				.wb_clk_i   (wb_clk_i),
				.rst_n_i    (rst_n_i),
				.req_sel_i  (dev_sel[d]),
				.ctrl_req_i (ctrl_req_i),
				.ctrl_rsp_o (arb_rsp[d]),
				.dev_req_o  (dev_req_o[d]),
				.dev_rsp_i  (dev_rsp_i[d])
			);
		end
	endgenerate

	// Back to the controllers
	wb_response_mux u_response_mux (
		.dev_idx_i  (dev_idx),
		.mapped_i   (mapped),
		.ctrl_req_i (ctrl_req_i),
		.arb_rsp_i  (arb_rsp),
		.ctrl_rsp_o (ctrl_rsp_o)
	);

endmodule

// ==== bench/wb_device_model.sv ====
`timescale 1ns/1ps

module wb_device_model import wb_pkg::*; #(
	parameter int DEV_ID = 0
) (
	input  logic        wb_clk_i,
	input  logic        rst_n_i,
	input  wb_dev_req_t dev_req_i,
	output wb_rsp_t     dev_rsp_o,

	// Last accepted request and a running count of accepts
	output wb_dev_req_t acc_req_o,
	output int          acc_cnt_o
);

	wb_dev_req_t req;
	logic        in_reset;
	logic        take;
	logic        bad_adr;

	initial begin
		dev_rsp_o = '0;
		acc_req_o = '0;
		acc_cnt_o = 0;
	end

	always begin
		// Mid-cycle sample, nothing moves here
		@(negedge wb_clk_i);
		req      = dev_req_i;
		in_reset = !rst_n_i;
		take     = !in_reset && req.cyc && req.stb && !dev_rsp_o.stall;
		if (take) begin
			acc_req_o = req;
			acc_cnt_o = acc_cnt_o + 1;
		end
		@(posedge wb_clk_i);
		#1;
		if (in_reset) begin
			dev_rsp_o = '0;
		end else if (take) begin
			// Top nibble of the device address all ones means error
			bad_adr               = &req.adr[DEV_ADR_W-1 -: 4];
			dev_rsp_o.ack         = !bad_adr;
			dev_rsp_o.error       = bad_adr;
			dev_rsp_o.stall       = 1'b0;
			dev_rsp_o.data        = {8'h00, req.adr} ^ {4'(DEV_ID), 28'h0};
		end else begin
			dev_rsp_o.ack   = 1'b0;
			dev_rsp_o.error = 1'b0;
			dev_rsp_o.data  = '0;
			dev_rsp_o.stall = 1'($urandom_range(0, 1));
		end
	end

endmodule

// ==== bench/wb_interconnect_tb.sv ====
`timescale 1ns/1ps

module wb_interconnect_tb import wb_pkg::*; ();

	localparam int CLK_PERIOD      = 100;
	localparam int RST_CYCLES      = 8;
	localparam int NUM_TXN         = 40;
	localparam int TXN_TOTAL       = NUM_CTRL * NUM_TXN;
	localparam int CYCLES_PER_TXN  = 64;

	logic        wb_clk_i = 1'b0;
	logic        rst_n_i  = 1'b0;
	wb_req_t     ctrl_req [NUM_CTRL];
	wb_rsp_t     ctrl_rsp [NUM_CTRL];
	wb_dev_req_t dev_req  [NUM_DEV];
	wb_rsp_t     dev_rsp  [NUM_DEV];
	wb_dev_req_t acc_req  [NUM_DEV];
	int          acc_cnt  [NUM_DEV];

	int          mapped_total;

	always #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;

	wb_interconnect dut0 (
		.wb_clk_i   (wb_clk_i),
		.rst_n_i    (rst_n_i),
		.ctrl_req_i (ctrl_req),
		.ctrl_rsp_o (ctrl_rsp),
		.dev_req_o  (dev_req),
		.dev_rsp_i  (dev_rsp)
	);

	genvar d;
	generate
		for (d = 0; d < NUM_DEV; d++) begin : g_dev
			wb_device_model #(.DEV_ID(d)) u_dev (
				.wb_clk_i  (wb_clk_i),
				.rst_n_i   (rst_n_i),
				.dev_req_i (dev_req[d]),
				.dev_rsp_o (dev_rsp[d]),
				.acc_req_o (acc_req[d]),
				.acc_cnt_o (acc_cnt[d])
			);
		end
	endgenerate

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "Mismatch in %s", name);
		end
	endtask

	// Quiet bus while controllers hold cyc low
	task automatic check_bus_idle(input string name);
		for (int i = 0; i < NUM_DEV; i++) begin
			check_value($sformatf("%s dev%0d cyc", name, i), 0, dev_req[i].cyc);
			check_value($sformatf("%s dev%0d stb", name, i), 0, dev_req[i].stb);
		end
		for (int i = 0; i < NUM_CTRL; i++) begin
			check_value($sformatf("%s ctrl%0d ack", name, i), 0, ctrl_rsp[i].ack);
		end
	endtask

	task automatic run_controller(input int c);
		wb_req_t              req;
		wb_rsp_t              rsp;
		logic [DEV_IDX_W-1:0] dev;
		logic [DEV_ADR_W-1:0] low_adr;
		logic [DATA_W-1:0]    exp_data;
		logic                 exp_err;
		logic                 in_stb;
		logic                 done;
		string                tag;
		for (int t = 0; t < NUM_TXN; t++) begin
			dev      = 4'($urandom_range(0, 15));
			low_adr  = 24'($urandom);
			req.cyc  = 1'b1;
			req.stb  = 1'b1;
			req.we   = 1'($urandom_range(0, 1));
			req.sel  = 4'($urandom);
			req.data = $urandom;
			req.adr  = {dev, low_adr};
			tag      = $sformatf("ctrl%0d txn%0d dev%0d", c, t, dev);
			repeat ($urandom_range(0, 2)) @(posedge wb_clk_i);
			@(posedge wb_clk_i);
			#1;
			ctrl_req[c] = req;
			if (dev >= NUM_DEV) begin
				// Answered combinationally, in the first cycle
				@(negedge wb_clk_i);
				rsp = ctrl_rsp[c];
				check_value({tag, " unmapped ack"}, 1, rsp.ack);
				check_value({tag, " unmapped error"}, 0, rsp.error);
				check_value({tag, " unmapped stall"}, 0, rsp.stall);
				check_value({tag, " unmapped data"}, 64'hffff_ffff, rsp.data);
				@(posedge wb_clk_i);
				#1;
				ctrl_req[c] = '0;
			end else begin
				mapped_total++;
				exp_err  = &low_adr[DEV_ADR_W-1 -: 4];
				exp_data = {8'h00, low_adr} ^ {dev, 28'h0};
				in_stb   = 1'b1;
				done     = 1'b0;
				while (!done) begin
					@(negedge wb_clk_i);
					rsp = ctrl_rsp[c];
					if (in_stb) begin
						// No answer before the device has taken the request
						check_value({tag, " ack before accept"}, 0, rsp.ack);
						check_value({tag, " error before accept"}, 0, rsp.error);
						if (!rsp.stall) begin
							in_stb = 1'b0;
						end
					end else if (rsp.ack || rsp.error) begin
						done = 1'b1;
						check_value({tag, " error"}, exp_err, rsp.error);
						check_value({tag, " ack"}, !exp_err, rsp.ack);
						if (rsp.ack) begin
							check_value({tag, " data"}, exp_data, rsp.data);
						end
						check_value({tag, " fwd we"}, req.we, acc_req[dev].we);
						check_value({tag, " fwd sel"}, req.sel, acc_req[dev].sel);
						check_value({tag, " fwd data"}, req.data, acc_req[dev].data);
						check_value({tag, " fwd adr"}, low_adr, acc_req[dev].adr);
					end
					@(posedge wb_clk_i);
					#1;
					if (done) begin
						ctrl_req[c] = '0;
					end else if (!in_stb) begin
						ctrl_req[c].stb = 1'b0;
					end
				end
			end
		end
	endtask

	// Watchdog
	initial begin
		#(TXN_TOTAL * CYCLES_PER_TXN * CLK_PERIOD);
		$display("Watchdog expired before all transactions completed");
		$display("=== FAIL ===");
		$fatal(1, "Timeout");
	end

	initial begin
		int accepted;
		void'($urandom(1));
		mapped_total = 0;
		accepted     = 0;
		for (int c = 0; c < NUM_CTRL; c++) begin
			ctrl_req[c] = '0;
		end

		repeat (RST_CYCLES) begin
			@(negedge wb_clk_i);
			check_bus_idle("reset");
		end
		@(posedge wb_clk_i);
		#1;
		rst_n_i = 1'b1;
		repeat (2) begin
			@(negedge wb_clk_i);
			check_bus_idle("after reset");
		end

		fork
			run_controller(0);
			run_controller(1);
			run_controller(2);
		join

		// Each mapped transfer is taken by a device exactly once
		for (int i = 0; i < NUM_DEV; i++) begin
			accepted += acc_cnt[i];
		end
		check_value("accepted count", mapped_total, accepted);

		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== project.f ====
src/wb_pkg.sv
src/wb_addr_decode.sv
src/wb_device_arbiter.sv
src/wb_response_mux.sv
src/wb_interconnect.sv
bench/wb_device_model.sv
bench/wb_interconnect_tb.sv
